/* run_sim.sh */
#!/bin/sh
# build and run the commit trace testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f verilog.f --top-module commit_tb -o commit_tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/commit_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation completed successfully"; then
  exit 0
fi
exit 1

/* src/commit_fifo.sv */
// show-ahead commit record FIFO
// with empty and almost-full levels
`default_nettype none
`timescale 1ns/1ps

module commit_fifo (
  input  wire                            clk,
  input  wire                            rst,
  input  wire                            i_push,
  input  wire commit_pkg::commit_rec_t   i_rec,
  input  wire                            i_pop,
  output commit_pkg::commit_rec_t        o_rec,
  output logic                           o_empty,
  output logic                           o_afull
);

  import commit_pkg::*;

  commit_rec_t        mem [FIFO_DEPTH];
  logic [FIFO_AW-1:0] wr_ptr;
  logic [FIFO_AW-1:0] rd_ptr;
  logic [FIFO_AW:0]   count;
  logic               full;
  logic               do_push;
  logic               do_pop;

  assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
  assign o_empty = (count == '0);
  // fewer than two free slots, one record may still be in flight
  assign o_afull = (count >= (FIFO_AW + 1)'(FIFO_DEPTH - 1));

  assign do_push = i_push & ~full;
  assign do_pop  = i_pop & ~o_empty;

  assign o_rec = mem[rd_ptr];  // head shown ahead

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= i_rec;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;  // idle or both
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* src/commit_pkg.sv */
// shared widths, FIFO depth, trap opcode, a0 index
// and the commit record passed from producer to trace sink
`default_nettype none

package commit_pkg;

  // datapath widths
  localparam int XLEN    = 64;
  localparam int ILEN    = 32;
  localparam int RIDX_W  = 5;
  localparam int WDEST_W = 8;

  // register a0 (x10) holds the exit code
  localparam logic [RIDX_W-1:0] A0_IDX = 5'd10;

  // custom major opcode that ends the run
  localparam logic [6:0] TRAP_OPCODE = 7'h6b;
  localparam int         TRAP_CODE_W = 3;

  // record queue
  localparam int FIFO_DEPTH = 4;
  localparam int FIFO_AW    = 2;

  // one retired instruction as seen by the trace sink
  typedef struct packed {
    logic [XLEN-1:0]        pc;
    logic [ILEN-1:0]        inst;
    logic                   wen;        // cleared for x0
    logic [WDEST_W-1:0]     wdest;
    logic [XLEN-1:0]        wdata;
    logic                   skip;
    logic                   is_trap;
    logic [TRAP_CODE_W-1:0] trap_code;  // a0 low bits before the trap
  } commit_rec_t;

endpackage

`default_nettype wire

/* src/commit_top.sv */
// commit trace top: producer, record FIFO and consumer
`default_nettype none
`timescale 1ns/1ps

module commit_top (
  input  wire                                clk,
  input  wire                                rst,
  input  wire [commit_pkg::RIDX_W-1:0]       i_rd,
  input  wire                                i_rd_wen,
  input  wire [commit_pkg::XLEN-1:0]         i_rd_wdata,
  input  wire [commit_pkg::XLEN-1:0]         i_pc,
  input  wire [commit_pkg::ILEN-1:0]         i_inst,
  input  wire [31:0]                         i_intr_no,
  input  wire                                i_cmtvalid,
  input  wire                                i_skipcmt,
  input  wire                                i_trace_hold,
  output wire                                o_stall,
  output wire                                o_trace_valid,
  output wire [commit_pkg::XLEN-1:0]         o_trace_pc,
  output wire [commit_pkg::ILEN-1:0]         o_trace_inst,
  output wire                                o_trace_wen,
  output wire [commit_pkg::WDEST_W-1:0]      o_trace_wdest,
  output wire [commit_pkg::XLEN-1:0]         o_trace_wdata,
  output wire                                o_trace_skip,
  output wire                                o_trap,
  output wire [commit_pkg::TRAP_CODE_W-1:0]  o_trap_code,
  output wire [commit_pkg::XLEN-1:0]         o_cycle_cnt,
  output wire [commit_pkg::XLEN-1:0]         o_instr_cnt
);

  import commit_pkg::*;

  commit_rec_t push_rec;  // producer register
  commit_rec_t head_rec;  // FIFO head
  logic        push;
  logic        pop;
  logic        empty;
  logic        afull;

  retire_gate u_retire_gate (
    .clk        (clk),
    .rst        (rst),
    .i_rd       (i_rd),
    .i_rd_wen   (i_rd_wen),
    .i_rd_wdata (i_rd_wdata),
    .i_pc       (i_pc),
    .i_inst     (i_inst),
    .i_intr_no  (i_intr_no),
    .i_cmtvalid (i_cmtvalid),
    .i_skipcmt  (i_skipcmt),
    .i_afull    (afull),
    .o_push     (push),
    .o_rec      (push_rec),
    .o_stall    (o_stall)
  );

  commit_fifo u_commit_fifo (
    .clk     (clk),
    .rst     (rst),
    .i_push  (push),
    .i_rec   (push_rec),
    .i_pop   (pop),
    .o_rec   (head_rec),
    .o_empty (empty),
    .o_afull (afull)
  );

  commit_tracker u_commit_tracker (
    .clk           (clk),
    .rst           (rst),
    .i_rec         (head_rec),
    .i_empty       (empty),
    .i_trace_hold  (i_trace_hold),
    .o_pop         (pop),
    .o_trace_valid (o_trace_valid),
    .o_trace_pc    (o_trace_pc),
    .o_trace_inst  (o_trace_inst),
    .o_trace_wen   (o_trace_wen),
    .o_trace_wdest (o_trace_wdest),
    .o_trace_wdata (o_trace_wdata),
    .o_trace_skip  (o_trace_skip),
    .o_trap        (o_trap),
    .o_trap_code   (o_trap_code),
    .o_cycle_cnt   (o_cycle_cnt),
    .o_instr_cnt   (o_instr_cnt)
  );

endmodule

`default_nettype wire

/* src/commit_tracker.sv */
// commit consumer: drains records to the trace ports,
// counts cycles and instructions, latches the trap
`default_nettype none
`timescale 1ns/1ps

module commit_tracker (
  input  wire                                clk,
  input  wire                                rst,
  input  wire commit_pkg::commit_rec_t       i_rec,
  input  wire                                i_empty,
  input  wire                                i_trace_hold,
  output logic                               o_pop,
  output logic                               o_trace_valid,
  output logic [commit_pkg::XLEN-1:0]        o_trace_pc,
  output logic [commit_pkg::ILEN-1:0]        o_trace_inst,
  output logic                               o_trace_wen,
  output logic [commit_pkg::WDEST_W-1:0]     o_trace_wdest,
  output logic [commit_pkg::XLEN-1:0]        o_trace_wdata,
  output logic                               o_trace_skip,
  output logic                               o_trap,
  output logic [commit_pkg::TRAP_CODE_W-1:0] o_trap_code,
  output logic [commit_pkg::XLEN-1:0]        o_cycle_cnt,
  output logic [commit_pkg::XLEN-1:0]        o_instr_cnt
);

  import commit_pkg::*;

  logic take_trap;

  // one record per cycle unless the sink holds
  assign o_pop     = ~i_empty & ~i_trace_hold;
  assign take_trap = o_pop & i_rec.is_trap;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_trace_valid <= 1'b0;
      o_trap        <= 1'b0;
      o_trap_code   <= '0;
      o_cycle_cnt   <= '0;
      o_instr_cnt   <= '0;
    end else begin
      o_trace_valid <= o_pop;
      if (take_trap) begin
        o_trap      <= 1'b1;  // sticky until reset
        o_trap_code <= i_rec.trap_code;
      end
      // both counters freeze once the trap is out
      if (~o_trap) begin
        o_cycle_cnt <= o_cycle_cnt + 1'b1;
        if (o_pop) begin
          o_instr_cnt <= o_instr_cnt + 1'b1;
        end
      end
    end
  end

  // trace payload, meaningful only with o_trace_valid
  always_ff @(posedge clk) begin
    if (o_pop) begin
      o_trace_pc    <= i_rec.pc;
      o_trace_inst  <= i_rec.inst;
      o_trace_wen   <= i_rec.wen;
      o_trace_wdest <= i_rec.wdest;
      o_trace_wdata <= i_rec.wdata;
      o_trace_skip  <= i_rec.skip;
    end
  end

endmodule

`default_nettype wire

/* src/retire_gate.sv */
// commit producer: filters retirements, tracks a0,
// tags the trap instruction and pushes records
`default_nettype none
`timescale 1ns/1ps

module retire_gate (
  input  wire                            clk,
  input  wire                            rst,
  input  wire [commit_pkg::RIDX_W-1:0]   i_rd,
  input  wire                            i_rd_wen,
  input  wire [commit_pkg::XLEN-1:0]     i_rd_wdata,
  input  wire [commit_pkg::XLEN-1:0]     i_pc,
  input  wire [commit_pkg::ILEN-1:0]     i_inst,
  input  wire [31:0]                     i_intr_no,
  input  wire                            i_cmtvalid,
  input  wire                            i_skipcmt,
  input  wire                            i_afull,
  output logic                           o_push,
  output commit_pkg::commit_rec_t        o_rec,
  output logic                           o_stall
);

  import commit_pkg::*;

  logic                   accept;
  logic                   is_trap;
  logic                   a0_write;
  logic                   trap_seen;   // sticky, blocks input until reset
  logic [TRAP_CODE_W-1:0] shadow_a0;   // only the exit code bits matter

  // interrupts and anything after the trap are dropped
  assign accept   = i_cmtvalid & (i_intr_no == '0) & ~trap_seen & ~i_afull;
  assign is_trap  = (i_inst[6:0] == TRAP_OPCODE);
  assign a0_write = i_rd_wen & (i_rd == A0_IDX);
  assign o_stall  = i_afull;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_push    <= 1'b0;
      trap_seen <= 1'b0;
      shadow_a0 <= '0;
    end else begin
      o_push <= accept;
      if (accept & is_trap) begin
        trap_seen <= 1'b1;
      end
      if (accept & a0_write) begin
        shadow_a0 <= i_rd_wdata[TRAP_CODE_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      o_rec.pc        <= i_pc;
      o_rec.inst      <= i_inst;
      o_rec.wen       <= i_rd_wen & (i_rd != '0);  // x0 never written
      o_rec.wdest     <= {{(WDEST_W - RIDX_W){1'b0}}, i_rd};
      o_rec.wdata     <= i_rd_wdata;
      o_rec.skip      <= i_skipcmt;
      o_rec.is_trap   <= is_trap;
      // shadow still holds the value from before this instruction
      o_rec.trap_code <= is_trap ? shadow_a0 : '0;
    end
  end

endmodule

`default_nettype wire

/* verif/commit_tb.sv */
// commit trace testbench with stimulus, a0 model and record scoreboard
// plus assertions on trace order, back-pressure and trap
`default_nettype none
`timescale 1ns/1ps

module commit_tb;

  import commit_pkg::*;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [4:0]  i_rd = '0;
  logic        i_rd_wen = 1'b0;
  logic [63:0] i_rd_wdata = '0;
  logic [63:0] i_pc = '0;
  logic [31:0] i_inst = '0;
  logic [31:0] i_intr_no = '0;
  logic        i_cmtvalid = 1'b0;
  logic        i_skipcmt = 1'b0;
  logic        i_trace_hold = 1'b0;
  wire         o_stall;
  wire         o_trace_valid;
  wire         o_trace_wen;
  wire         o_trace_skip;
  wire         o_trap;
  wire [63:0]  o_trace_pc;
  wire [63:0]  o_trace_wdata;
  wire [63:0]  o_cycle_cnt;
  wire [63:0]  o_instr_cnt;
  wire [31:0]  o_trace_inst;
  wire [7:0]   o_trace_wdest;
  wire [2:0]   o_trap_code;

  commit_rec_t exp_q[$];     // records still owed by the trace
  logic [63:0] a0_model = '0;
  bit          trap_sent = 1'b0;
  integer      seed = 32'h11c96960;
  int          errors = 0;
  int          accepted = 0;  // records the model expects to be traced
  int          n_pass = 0;
  int          n_fail = 0;

  always #2 clk = ~clk;

  commit_top u_commit_top (.*);

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp) else begin
      $display("FAIL %s got %h expected %h", name, got, exp);
      errors++;
    end
  endtask

  // scoreboard checks at the falling edge
  always @(negedge clk) begin
    commit_rec_t e;
    if (!rst && o_trace_valid) begin
      if (exp_q.size() == 0) begin
        $display("trace record at pc %h was never retired", o_trace_pc);
        errors++;
      end else begin
        e = exp_q.pop_front();
        check_val("o_trace_pc", o_trace_pc, e.pc);
        check_val("o_trace_inst", o_trace_inst, e.inst);
        check_val("o_trace_wen", o_trace_wen, e.wen);
        check_val("o_trace_wdest", o_trace_wdest, e.wdest);
        check_val("o_trace_wdata", o_trace_wdata, e.wdata);
        check_val("o_trace_skip", o_trace_skip, e.skip);
        check_val("o_instr_cnt", o_instr_cnt, 64'(accepted - exp_q.size()));
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) $past(i_trace_hold) |-> !o_trace_valid)
    else begin
      $display("trace output appeared while the sink was held");
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst) $past(o_trap) |-> !o_trace_valid)
    else begin
      $display("trace output appeared after the trap record");
      errors++;
    end

  assert property (@(posedge clk) disable iff (rst)
      o_trap |=> ($stable(o_cycle_cnt) && $stable(o_instr_cnt)))
    else begin
      $display("counters kept moving after the trap");
      errors++;
    end

  // presents one retirement for one cycle and obeys o_stall
  task automatic retire(input logic valid, input logic [4:0] rd, input logic wen,
                        input logic [63:0] wdata, input logic [31:0] inst,
                        input logic [31:0] intr);
    commit_rec_t r;
    logic [31:0] rnd;
    int          t;
    t = 0;
    while (o_stall && t < 50) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (o_stall) begin
      $display("timeout waiting for o_stall to fall");
      errors++;
    end
    rnd        = $random(seed);
    i_cmtvalid = valid;
    i_rd       = rd;
    i_rd_wen   = wen;
    i_rd_wdata = wdata;
    i_inst     = inst;
    i_intr_no  = intr;
    i_pc       = {$random(seed), $random(seed)};
    i_skipcmt  = rnd[16];
    if (valid && intr == 32'd0 && !trap_sent && !o_stall) begin
      r.pc        = i_pc;
      r.inst      = inst;
      r.wen       = wen && (rd != 5'd0);
      r.wdest     = {3'b000, rd};
      r.wdata     = wdata;
      r.skip      = i_skipcmt;
      r.is_trap   = (inst[6:0] == 7'h6b);
      r.trap_code = a0_model[2:0];
      exp_q.push_back(r);
      accepted++;
      if (wen && rd == 5'd10) a0_model = wdata;
      if (r.is_trap) trap_sent = 1'b1;
    end
    @(posedge clk);
    #1;
    i_cmtvalid = 1'b0;
  endtask

  task automatic random_retire(input bit allow_intr);
    logic [31:0] r;
    logic [31:0] inst;
    r    = $random(seed);
    inst = $random(seed);
    if (inst[6:0] == 7'h6b) inst[0] = 1'b0;  // keep the trap out
    retire(r[9:8] != 2'b00, r[4:0], r[5], {$random(seed), $random(seed)}, inst,
           (allow_intr && r[14:12] == 3'd0) ? 32'd7 : 32'd0);
  endtask

  task automatic wait_drain();
    int t;
    t = 0;
    while (exp_q.size() != 0 && t < 100) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (exp_q.size() != 0) begin
      $display("timeout with %0d records never traced", exp_q.size());
      errors++;
    end
  endtask

  task automatic latency_probe(input logic [4:0] rd);
    int edges;
    wait_drain();
    retire(1'b1, rd, 1'b1, {$random(seed), $random(seed)}, 32'h0000_0033, 32'd0);
    edges = 1;
    while (!o_trace_valid && edges < 10) begin
      @(posedge clk);
      #1;
      edges++;
    end
    check_val("trace latency", edges, 3);
  endtask

  task automatic end_test(input string name, input int err_before);
    if (errors == err_before) begin
      $display("test %s passed", name);
      n_pass++;
    end else begin
      $display("test %s failed", name);
      n_fail++;
    end
  endtask

  initial begin
    int          errs;
    int          i;
    int          t;
    logic [63:0] cnt0;
    logic [63:0] cyc0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    errs = errors;
    check_val("o_trace_valid", o_trace_valid, 0);
    check_val("o_trap", o_trap, 0);
    check_val("o_stall", o_stall, 0);
    check_val("o_instr_cnt", o_instr_cnt, 0);
    end_test("reset", errs);

    errs = errors;
    latency_probe(5'd0);
    latency_probe(5'd17);
    for (i = 0; i < 30; i++) random_retire(1'b0);
    wait_drain();
    end_test("trace_order", errs);

    errs = errors;
    cnt0 = o_instr_cnt;
    for (i = 0; i < 4; i++) begin
      retire(1'b1, 5'd3, 1'b1, {$random(seed), $random(seed)}, 32'h13, 32'd5);
      retire(1'b0, 5'd4, 1'b1, {$random(seed), $random(seed)}, 32'h13, 32'd0);
    end
    repeat (6) @(posedge clk);
    #1;
    check_val("o_instr_cnt", o_instr_cnt, cnt0);
    end_test("filtered", errs);

    errs = errors;
    i_trace_hold = 1'b1;
    i = 0;
    while (!o_stall && i < 12) begin
      retire(1'b1, 5'd10, 1'b1, {$random(seed), $random(seed)}, 32'h13, 32'd0);
      i++;
    end
    if (!o_stall) begin
      $display("o_stall never rose while the trace was held");
      errors++;
    end
    i_trace_hold = 1'b0;
    for (i = 0; i < 6; i++) random_retire(1'b0);
    wait_drain();
    end_test("backpressure", errs);

    errs = errors;
    for (i = 0; i < 60; i++) begin
      i_trace_hold = o_stall ? 1'b0 : ($random(seed) % 3 == 0);
      random_retire(1'b1);
    end
    i_trace_hold = 1'b0;
    wait_drain();
    end_test("random_mix", errs);

    errs = errors;
    retire(1'b1, 5'd10, 1'b1, {$random(seed), $random(seed)}, 32'h00a0_0513, 32'd0);
    retire(1'b1, 5'd0, 1'b0, 64'd0, {$random(seed)} << 7 | 32'h6b, 32'd0);
    for (i = 0; i < 4; i++) random_retire(1'b0);
    t = 0;
    while (!o_trap && t < 50) begin
      @(posedge clk);
      #1;
      t++;
    end
    if (!o_trap) begin
      $display("timeout waiting for o_trap");
      errors++;
    end
    @(posedge clk);
    #1;
    check_val("o_trap_code", o_trap_code, a0_model[2:0]);
    check_val("o_instr_cnt", o_instr_cnt, 64'(accepted));
    cnt0 = o_instr_cnt;
    cyc0 = o_cycle_cnt;
    for (i = 0; i < 4; i++) random_retire(1'b0);
    repeat (8) @(posedge clk);
    #1;
    check_val("o_instr_cnt", o_instr_cnt, cnt0);
    check_val("o_cycle_cnt", o_cycle_cnt, cyc0);
    end_test("trap", errs);

    $display("tests passed: %0d failed: %0d", n_pass, n_fail);
    if (errors == 0 && n_fail == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/commit_pkg.sv
src/retire_gate.sv
src/commit_fifo.sv
src/commit_tracker.sv
src/commit_top.sv
verif/commit_tb.sv
